// File: atc_settings.svh
`ifndef ATC_SETTINGS_SVH
`define ATC_SETTINGS_SVH

// Width of an aircraft ID in the request and reply words.
`define ATC_ID_WIDTH 4

// One pool entry per possible ID, so this is two to the power of the ID width.
`define ATC_NUM_IDS 16

`define ATC_QUEUE_DEPTH 4 // Planes waiting per queue.

`define ATC_REQ_DEPTH 2 // Incoming words buffered ahead of the controller.

`endif

// File: atc_pkg.sv
`default_nettype none
`include "atc_settings.svh"

package atc_pkg;

	// Request types that the tower understands. Anything else gets say again.
	typedef enum logic [2:0] {
		runway_req  = 3'b000,
		runway_done = 3'b001,
		id_req      = 3'b111
	} msg_type_e;

	typedef enum logic [2:0] {
		clear     = 3'b011,
		hold      = 3'b100,
		say_again = 3'b101,
		divert    = 3'b110,
		id_reply  = 3'b111
	} reply_type_e;

	typedef struct packed {
		logic [`ATC_ID_WIDTH-1:0] plane_id;
		msg_type_e msg_type;
		logic [1:0] action; // Bit 1 selects landing, bit 0 the runway.
	} request_t;

	typedef struct packed {
		logic [`ATC_ID_WIDTH-1:0] plane_id;
		reply_type_e reply_type;
		logic [1:0] action;
	} reply_t;

	typedef enum logic [2:0] {
		idle,
		decode,
		send,
		dispatch,
		send_clear
	} tower_state_e;

endpackage

`default_nettype wire

// File: atc_ifs.sv
`timescale 1ns/100ps
`default_nettype none
`include "atc_settings.svh"

// Link between the controller and the ID pool.
interface id_pool_if;
	logic [`ATC_ID_WIDTH-1:0] query_id;
	logic query_taken;
	logic take;
	logic release_id; // Frees query_id at the next edge.
	logic [`ATC_ID_WIDTH-1:0] free_id;
	logic empty;

	modport controller (output query_id, take, release_id, input query_taken, free_id, empty);
	modport pool (input query_id, take, release_id, output query_taken, free_id, empty);
endinterface

// Link between the controller and the runway scheduler.
interface runway_if;
	logic enqueue;
	logic enqueue_landing;
	logic [`ATC_ID_WIDTH-1:0] plane_id;
	logic queue_full;
	logic vacate;
	logic vacate_runway;
	logic dispatch_ready;
	logic dispatch;
	logic [`ATC_ID_WIDTH-1:0] cleared_id; // The cleared_* signals are valid one cycle after dispatch.
	logic cleared_landing;
	logic cleared_runway;

	modport controller (
		output enqueue, enqueue_landing, plane_id, vacate, vacate_runway, dispatch,
		input queue_full, dispatch_ready, cleared_id, cleared_landing, cleared_runway
	);
	modport scheduler (
		input enqueue, enqueue_landing, plane_id, vacate, vacate_runway, dispatch,
		output queue_full, dispatch_ready, cleared_id, cleared_landing, cleared_runway
	);
endinterface

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 9,
	parameter int DEPTH = 2
) (
	input logic clock,
	input logic reset,
	input logic write,
	input logic [WIDTH-1:0] write_data,
	input logic read,
	output logic [WIDTH-1:0] read_data,
	output logic full,
	output logic empty
);
	// DEPTH is a power of two, so the pointers wrap on their own.
	localparam int PTR_WIDTH = $clog2(DEPTH);
	localparam logic [PTR_WIDTH:0] FULL_COUNT = DEPTH[PTR_WIDTH:0];

	logic [WIDTH-1:0] storage [DEPTH];
	logic [PTR_WIDTH-1:0] put_ptr;
	logic [PTR_WIDTH-1:0] get_ptr;
	logic [PTR_WIDTH:0] count;
	logic do_write;
	logic do_read;

	assign empty = (count == '0);
	assign full = (count == FULL_COUNT);
	assign do_write = write && !full; // Writes into a full buffer are lost.
	assign do_read = read && !empty;

	always_ff @(posedge clock) begin
		if (reset) begin
			put_ptr <= '0;
			get_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write)
				put_ptr <= put_ptr + 1'b1;
			if (do_read)
				get_ptr <= get_ptr + 1'b1;
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_write)
			storage[put_ptr] <= write_data;
		if (do_read)
			read_data <= storage[get_ptr]; // Head word shows up the cycle after read.
	end
endmodule

`default_nettype wire

// File: id_pool.sv
`timescale 1ns/100ps
`default_nettype none
`include "atc_settings.svh"

module id_pool (
	input logic clock,
	input logic reset,
	id_pool_if.pool pool
);
	logic [`ATC_NUM_IDS-1:0] taken; // One bit per aircraft ID.

	assign pool.query_taken = taken[pool.query_id];
	assign pool.empty = &taken;

	// Lowest free ID wins, since the loop runs from the top down.
	always_comb begin
		pool.free_id = '0;
		for (int i = `ATC_NUM_IDS - 1; i >= 0; i--) begin
			if (!taken[i])
				pool.free_id = i[`ATC_ID_WIDTH-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			taken <= '0;
		else if (pool.release_id)
			taken[pool.query_id] <= 1'b0;
		else if (pool.take)
			taken[pool.free_id] <= 1'b1; // The controller never takes from an empty pool.
	end
endmodule

`default_nettype wire

// File: runway_scheduler.sv
`timescale 1ns/100ps
`default_nettype none
`include "atc_settings.svh"

module runway_scheduler (
	input logic clock,
	input logic reset,
	runway_if.scheduler sched,
	output logic [1:0] runway_active
);
	logic takeoff_full;
	logic takeoff_empty;
	logic landing_full;
	logic landing_empty;
	logic [`ATC_ID_WIDTH-1:0] takeoff_head;
	logic [`ATC_ID_WIDTH-1:0] landing_head;
	logic [1:0] busy;
	logic [`ATC_ID_WIDTH-1:0] runway_plane [2];
	logic last_landing;
	logic pick_landing;
	logic pick_runway;
	logic fill;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Plane queues
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	sync_fifo #(
		.WIDTH(`ATC_ID_WIDTH),
		.DEPTH(`ATC_QUEUE_DEPTH)
	) takeoff_queue (
		.clock(clock),
		.reset(reset),
		.write(sched.enqueue && !sched.enqueue_landing),
		.write_data(sched.plane_id),
		.read(sched.dispatch && !pick_landing),
		.read_data(takeoff_head),
		.full(takeoff_full),
		.empty(takeoff_empty)
	);

	sync_fifo #(
		.WIDTH(`ATC_ID_WIDTH),
		.DEPTH(`ATC_QUEUE_DEPTH)
	) landing_queue (
		.clock(clock),
		.reset(reset),
		.write(sched.enqueue && sched.enqueue_landing),
		.write_data(sched.plane_id),
		.read(sched.dispatch && pick_landing),
		.read_data(landing_head),
		.full(landing_full),
		.empty(landing_empty)
	);

	assign sched.queue_full = sched.enqueue_landing ? landing_full : takeoff_full;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Dispatch choice and runway occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// With both queues waiting, serve the one not popped last time.
	assign pick_landing = takeoff_empty || (!landing_empty && !last_landing);
	assign pick_runway = busy[0]; // Lowest-numbered free runway.
	assign sched.dispatch_ready = !(takeoff_empty && landing_empty) && !(&busy);
	assign sched.cleared_id = sched.cleared_landing ? landing_head : takeoff_head;
	assign runway_active = busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 2'b00;
			last_landing <= 1'b1; // Takeoff goes first after reset.
			fill <= 1'b0;
		end else begin
			fill <= sched.dispatch;
			if (sched.dispatch) begin
				busy[pick_runway] <= 1'b1;
				last_landing <= pick_landing;
			end else if (sched.vacate &&
					runway_plane[sched.vacate_runway] == sched.plane_id) begin
				busy[sched.vacate_runway] <= 1'b0;
			end
		end
	end

	// The popped ID leaves the queue a cycle after dispatch, so it is stored then.
	always_ff @(posedge clock) begin
		if (sched.dispatch) begin
			sched.cleared_landing <= pick_landing;
			sched.cleared_runway <= pick_runway;
		end
		if (fill)
			runway_plane[sched.cleared_runway] <= sched.cleared_id;
	end
endmodule

`default_nettype wire

// File: tower_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module tower_fsm (
	input logic clock,
	input logic reset,
	input logic request_empty,
	output logic request_read,
	input atc_pkg::request_t request,
	id_pool_if.controller pool,
	runway_if.controller sched,
	output logic reply_valid,
	output atc_pkg::reply_t reply_data
);
	atc_pkg::tower_state_e state;
	atc_pkg::tower_state_e next_state;
	atc_pkg::reply_t next_reply;
	logic load_reply;

	// Every request field goes straight to the pool and scheduler.
	assign pool.query_id = request.plane_id;
	assign sched.plane_id = request.plane_id;
	assign sched.enqueue_landing = request.action[1];
	assign sched.vacate_runway = request.action[0];

	assign reply_valid = (state == atc_pkg::send) || (state == atc_pkg::send_clear);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state and strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_state = state;
		request_read = 1'b0;
		pool.take = 1'b0;
		pool.release_id = 1'b0;
		sched.enqueue = 1'b0;
		sched.vacate = 1'b0;
		sched.dispatch = 1'b0;
		load_reply = 1'b0;
		next_reply = '{
			plane_id: request.plane_id,
			reply_type: atc_pkg::say_again,
			action: 2'b00
		};

		case (state)
			atc_pkg::idle: begin
				// Requests come before clearances.
				if (!request_empty) begin
					request_read = 1'b1;
					next_state = atc_pkg::decode;
				end else if (sched.dispatch_ready) begin
					sched.dispatch = 1'b1;
					next_state = atc_pkg::dispatch;
				end
			end

			atc_pkg::decode: begin
				case (request.msg_type)
					atc_pkg::runway_req: begin
						if (pool.query_taken) begin
							load_reply = 1'b1;
							if (sched.queue_full) begin
								next_reply.reply_type = atc_pkg::divert;
								pool.release_id = 1'b1; // A diverted plane gives its ID back.
							end else begin
								next_reply.reply_type = atc_pkg::hold;
								sched.enqueue = 1'b1;
							end
						end
					end
					atc_pkg::runway_done: begin
						if (pool.query_taken) begin
							sched.vacate = 1'b1;
							pool.release_id = 1'b1;
						end
					end
					atc_pkg::id_req: begin
						load_reply = 1'b1;
						next_reply.reply_type = atc_pkg::id_reply;
						if (pool.empty) begin
							next_reply.plane_id = '0;
							next_reply.action = 2'b11; // No ID left.
						end else begin
							next_reply.plane_id = pool.free_id;
							pool.take = 1'b1;
						end
					end
					default: load_reply = 1'b1;
				endcase
				next_state = load_reply ? atc_pkg::send : atc_pkg::idle;
			end

			atc_pkg::dispatch: begin
				load_reply = 1'b1;
				next_reply = '{
					plane_id: sched.cleared_id,
					reply_type: atc_pkg::clear,
					action: {sched.cleared_landing, sched.cleared_runway}
				};
				next_state = atc_pkg::send_clear;
			end

			default: next_state = atc_pkg::idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= atc_pkg::idle;
			reply_data <= '0;
		end else begin
			state <= next_state;
			if (load_reply)
				reply_data <= next_reply; // Held through send or send_clear.
		end
	end
endmodule

`default_nettype wire

// File: atc_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "atc_settings.svh"

module atc_top (
	input logic clock,
	input logic reset,
	input logic request_valid,
	input logic [8:0] request_data,
	output logic reply_valid,
	output logic [8:0] reply_data,
	output logic [1:0] runway_active
);
	atc_pkg::request_t request_word;
	logic request_read;
	logic request_empty;

	id_pool_if pool_bus ();
	runway_if runway_bus ();

	// Small buffer so a request can land while the controller is busy.
	sync_fifo #(
		.WIDTH($bits(atc_pkg::request_t)),
		.DEPTH(`ATC_REQ_DEPTH)
	) request_buffer (
		.clock(clock),
		.reset(reset),
		.write(request_valid),
		.write_data(request_data),
		.read(request_read),
		.read_data(request_word),
		.full(),
		.empty(request_empty)
	);

	id_pool pool (
		.clock(clock),
		.reset(reset),
		.pool(pool_bus.pool)
	);

	runway_scheduler scheduler (
		.clock(clock),
		.reset(reset),
		.sched(runway_bus.scheduler),
		.runway_active(runway_active)
	);

	tower_fsm controller (
		.clock(clock),
		.reset(reset),
		.request_empty(request_empty),
		.request_read(request_read),
		.request(request_word),
		.pool(pool_bus.controller),
		.sched(runway_bus.controller),
		.reply_valid(reply_valid),
		.reply_data(reply_data)
	);
endmodule

`default_nettype wire

// File: atc_sva.sv
`timescale 1ns/100ps
`default_nettype none

module atc_sva (
	input logic clock,
	input logic reset,
	input logic request_valid,
	input logic [8:0] request_data,
	input logic reply_valid,
	input logic [8:0] reply_data,
	input logic [1:0] runway_active
);
	logic done_seen;

	assign done_seen = request_valid && request_data[4:2] == 3'b001;

	single_reply: assert property (@(posedge clock) disable iff (reset)
		reply_valid |=> !reply_valid)
		else $error("reply_valid held for two cycles");

	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !reply_valid && runway_active == 2'b00 && reply_data == 9'd0)
		else $error("outputs not idle after reset");

	// A runway comes into use one cycle ahead of its clear reply.
	rise_then_clear: assert property (@(posedge clock) disable iff (reset)
		|(runway_active & ~$past(runway_active)) |=> reply_valid && reply_data[4:2] == 3'b011)
		else $error("runway taken without a clear reply");

	// The controller may finish a clearance before it reads the runway done.
	fall_after_done: assert property (@(posedge clock) disable iff (reset)
		|(~runway_active & $past(runway_active)) |->
			$past(done_seen, 3) || $past(done_seen, 4) || $past(done_seen, 5))
		else $error("runway freed without a runway done request");
endmodule

bind atc_top atc_sva sva (
	.clock(clock),
	.reset(reset),
	.request_valid(request_valid),
	.request_data(request_data),
	.reply_valid(reply_valid),
	.reply_data(reply_data),
	.runway_active(runway_active)
);

`default_nettype wire

// File: tb_atc.sv
`timescale 1ns/100ps
`default_nettype none
`include "atc_settings.svh"

module tb_atc;
	localparam int TIMEOUT = 50;
	localparam int QUIET = 12; // Idle cycles that follow and space out the requests.

	logic clock = 1'b0;
	logic reset;
	logic request_valid;
	logic [8:0] request_data;
	logic reply_valid;
	logic [8:0] reply_data;
	logic [1:0] runway_active;

	integer seed = 32'h9f75_40e5;
	int errors = 0;
	int timeouts = 0;

	// Reply model state.
	logic [`ATC_NUM_IDS-1:0] taken = '0;
	logic [`ATC_ID_WIDTH-1:0] takeoff_q [$];
	logic [`ATC_ID_WIDTH-1:0] landing_q [$];
	logic [1:0] busy = 2'b00;
	logic [`ATC_ID_WIDTH-1:0] runway_plane [2];
	logic last_landing = 1'b0;
	logic [8:0] expected [$];

	always #2 clock = ~clock;

	atc_top DUT (
		.clock(clock),
		.reset(reset),
		.request_valid(request_valid),
		.request_data(request_data),
		.reply_valid(reply_valid),
		.reply_data(reply_data),
		.runway_active(runway_active)
	);

	function automatic logic [8:0] request_word(input logic [3:0] id, input logic [2:0] kind,
			input logic [1:0] action);
		return {id, kind, action};
	endfunction

	function automatic logic [`ATC_ID_WIDTH-1:0] lowest_free();
		for (int i = 0; i < `ATC_NUM_IDS; i++) begin
			if (!taken[i])
				return 4'(i);
		end
		return '0;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reply model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic predict(input logic [8:0] word);
		logic [`ATC_ID_WIDTH-1:0] id;
		logic [`ATC_ID_WIDTH-1:0] free;
		logic landing;
		logic runway;
		int queued;
		id = word[8:5];
		case (word[4:2])
			3'b111: begin
				if (&taken) begin
					expected.push_back(9'b0000_111_11);
				end else begin
					free = lowest_free();
					taken[free] = 1'b1;
					expected.push_back({free, 3'b111, 2'b00});
				end
			end
			3'b000: begin
				landing = word[1];
				queued = landing ? landing_q.size() : takeoff_q.size();
				if (taken[id] && queued == `ATC_QUEUE_DEPTH) begin
					taken[id] = 1'b0; // Diverted, so the ID goes back to the pool.
					expected.push_back({id, 3'b110, 2'b00});
				end else if (taken[id]) begin
					expected.push_back({id, 3'b100, 2'b00});
					if (landing)
						landing_q.push_back(id);
					else
						takeoff_q.push_back(id);
				end
			end
			3'b001: begin
				if (taken[id]) begin
					taken[id] = 1'b0;
					if (runway_plane[word[0]] == id)
						busy[word[0]] = 1'b0;
				end
			end
			default: expected.push_back({id, 3'b101, 2'b00});
		endcase
		// Every return to idle clears one waiting plane if a runway is free.
		while (takeoff_q.size() + landing_q.size() != 0 && busy != 2'b11) begin
			if (takeoff_q.size() != 0 && landing_q.size() != 0)
				landing = !last_landing; // Both queues wait, so the other one goes.
			else
				landing = landing_q.size() != 0;
			if (!busy[0])
				runway = 1'b0;
			else
				runway = 1'b1;
			id = landing ? landing_q.pop_front() : takeoff_q.pop_front();
			busy[runway] = 1'b1;
			runway_plane[runway] = id;
			last_landing = landing;
			expected.push_back({id, 3'b011, landing, runway});
		end
	endtask

	task automatic issue(input logic [8:0] word);
		logic [8:0] want;
		int wait_cycles;
		predict(word);
		@(posedge clock);
		request_valid <= 1'b1;
		request_data <= word;
		@(posedge clock);
		request_valid <= 1'b0;
		while (expected.size() != 0) begin
			want = expected.pop_front();
			wait_cycles = 0;
			@(negedge clock);
			while (!reply_valid && wait_cycles < TIMEOUT) begin
				@(negedge clock);
				wait_cycles++;
			end
			if (!reply_valid) begin
				$display("Timeout: reply %h to request %h never arrived", want, word);
				timeouts++;
			end else begin
				assert (reply_data == want) else begin
					$display("Fail at %0t: reply %h, expected %h", $time, reply_data, want);
					errors++;
				end
			end
		end
		repeat (QUIET) begin
			@(negedge clock);
			assert (!reply_valid) else begin
				$display("Fail at %0t: unexpected reply %h", $time, reply_data);
				errors++;
			end
		end
		assert (runway_active == busy) else begin
			$display("Fail at %0t: runway_active %b, expected %b", $time, runway_active, busy);
			errors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [31:0] r;
		logic runway;
		reset = 1'b1;
		request_valid = 1'b0;
		request_data = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		repeat (`ATC_NUM_IDS + 1) issue(request_word(4'd0, 3'b111, 2'b00));

		issue(request_word(4'd0, 3'b000, 2'b00)); // Runway 0.
		issue(request_word(4'd1, 3'b000, 2'b00)); // Runway 1.
		for (int i = 2; i < 7; i++)
			issue(request_word(4'(i), 3'b000, 2'b00)); // The fifth one is diverted.
		issue(request_word(4'd0, 3'b111, 2'b00));

		// Two landings wait behind the takeoffs.
		issue(request_word(4'd7, 3'b000, 2'b10));
		issue(request_word(4'd8, 3'b000, 2'b10));
		repeat (4) begin
			r = $random(seed);
			runway = r[0];
			issue(request_word(runway_plane[runway], 3'b001, {1'b0, runway}));
		end

		r = $random(seed);
		issue(request_word(4'd9, 3'd2 + (r[2:0] % 3'd5), 2'b00));
		issue(request_word(lowest_free(), 3'b000, 2'b00));
		issue(request_word(4'd6, 3'b001, 2'b00)); // Plane 6 holds no runway.

		$display("Errors: %0d wrong values, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
atc_pkg.sv
atc_ifs.sv
sync_fifo.sv
id_pool.sv
runway_scheduler.sv
tower_fsm.sv
atc_top.sv
atc_sva.sv
tb_atc.sv

// File: run.sh
#!/bin/sh
# Build and run the ATC testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module tb_atc -f vlog.f -o sim_atc
./obj_dir/sim_atc | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
else
	exit 1
fi
